// ==== gat_softmax_consts.svh ====
`ifndef GAT_SOFTMAX_CONSTS_SVH
`define GAT_SOFTMAX_CONSTS_SVH

// coefficient exponent width
`define GS_COEF_W 4

// largest subgraph
`define GS_MAX_NODES 16

// node-count memory address width
`define GS_NODE_ADDR_W 8

// fraction bits of alpha
`define GS_ALPHA_FRAC 8

// issue to alpha_wr, in cycles
`define GS_DIV_LAT 10

`define GS_DIVIDEND_DEPTH 32
`define GS_DIVISOR_DEPTH 4

`endif

// ==== gat_softmax_pkg.sv ====
package gat_softmax_pkg;

  `include "gat_softmax_consts.svh"

  localparam int EXP_W   = 1 << `GS_COEF_W;
  localparam int SUM_W   = EXP_W + $clog2(`GS_MAX_NODES);
  localparam int CNT_W   = $clog2(`GS_MAX_NODES) + 1;
  // one integer bit, alpha never exceeds 1.0
  localparam int ALPHA_W = `GS_ALPHA_FRAC + 1;

  typedef logic [`GS_COEF_W-1:0]      coef_t;
  typedef logic [EXP_W-1:0]           exp_t;
  typedef logic [SUM_W-1:0]           sum_t;
  typedef logic [CNT_W-1:0]           node_cnt_t;
  typedef logic [`GS_NODE_ADDR_W-1:0] node_addr_t;
  typedef logic [ALPHA_W-1:0]         alpha_t;

  // divisor fifo entry
  typedef struct packed {
    node_cnt_t num_nodes;
    sum_t      sum;
  } group_sum_t;

  typedef enum logic [1:0] {
    S_FETCH,
    S_ACCUM,
    S_WAIT
  } ctrl_state_e;

endpackage

// ==== sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
  parameter int WIDTH = 16,
  parameter int DEPTH = 32
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [WIDTH-1:0] din,
  input  logic             wr,
  input  logic             rd,
  output logic [WIDTH-1:0] dout,
  output logic             full,
  output logic             empty
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_wr;
  logic             do_rd;

  assign do_wr = wr & ~full;
  assign do_rd = rd & ~empty;
  assign full  = (count == (PTR_W + 1)'(DEPTH));
  assign empty = (count == '0);
  // show-ahead head
  assign dout  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== exp_sum_unit.sv ====
`timescale 1ns/1ps

module exp_sum_unit import gat_softmax_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  coef_t      coef,
  input  logic       coef_rd,
  input  logic       acc_first,
  input  logic       acc_last,
  input  node_cnt_t  group_len,
  output exp_t       exp,
  output logic       exp_push,
  output group_sum_t group_sum,
  output logic       sum_push
);
  sum_t      exp_ext;
  sum_t      sum_q;
  node_cnt_t len_q;
  logic      last_q;

  // 2^coef as a one-hot word
  always_comb begin
    exp       = '0;
    exp[coef] = 1'b1;
  end

  assign exp_ext  = sum_t'(exp);
  // exp goes to the dividend fifo with its read
  assign exp_push = coef_rd;

  // running sum, restarted on the first beat
  always_ff @(posedge clk) begin
    if (coef_rd) begin
      if (acc_first) begin
        sum_q <= exp_ext;
      end else begin
        sum_q <= sum_q + exp_ext;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (coef_rd && acc_last) begin
      len_q <= group_len;
    end
  end

  // sum is complete the cycle after the last beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_q <= 1'b0;
    end else begin
      last_q <= coef_rd & acc_last;
    end
  end

  assign sum_push  = last_q;
  assign group_sum = '{num_nodes: len_q, sum: sum_q};

endmodule

// ==== fxp_div_pipe.sv ====
`timescale 1ns/1ps
`include "gat_softmax_consts.svh"

module fxp_div_pipe import gat_softmax_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   div_issue,
  input  logic   div_load,
  input  exp_t   dividend,
  input  sum_t   divisor,
  output alpha_t alpha,
  output logic   alpha_wr
);
  // one quotient bit per stage, then the output register
  localparam int STAGES = `GS_DIV_LAT - 1;
  localparam int REM_W  = $bits(sum_t) + STAGES;

  sum_t             div_q;
  sum_t             div_cur;
  logic             vld_q [STAGES];
  logic [REM_W-1:0] rem_q [STAGES];
  sum_t             dsr_q [STAGES];
  alpha_t           quo_q [STAGES];

  always_ff @(posedge clk) begin
    if (div_load) begin
      div_q <= divisor;
    end
  end

  // a load and an issue together use the new divisor
  assign div_cur = div_load ? divisor : div_q;

  for (genvar k = 0; k < STAGES; k++) begin : g_stage
    localparam int SH = STAGES - 1 - k;
    logic             vld_in;
    logic [REM_W-1:0] rem_in;
    sum_t             dsr_in;
    alpha_t           quo_in;
    logic [REM_W-1:0] dsr_sh;

    if (k == 0) begin : g_head
      // dividend scaled by 2^frac
      assign vld_in = div_issue;
      assign rem_in = REM_W'(dividend) << `GS_ALPHA_FRAC;
      assign dsr_in = div_cur;
      assign quo_in = '0;
    end else begin : g_body
      assign vld_in = vld_q[k-1];
      assign rem_in = rem_q[k-1];
      assign dsr_in = dsr_q[k-1];
      assign quo_in = quo_q[k-1];
    end

    assign dsr_sh = REM_W'(dsr_in) << SH;

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        vld_q[k] <= 1'b0;
      end else begin
        vld_q[k] <= vld_in;
      end
    end

    // restoring step, msb of the quotient first
    always_ff @(posedge clk) begin
      dsr_q[k] <= dsr_in;
      if (rem_in >= dsr_sh) begin
        rem_q[k] <= rem_in - dsr_sh;
        quo_q[k] <= quo_in | alpha_t'(1 << SH);
      end else begin
        rem_q[k] <= rem_in;
        quo_q[k] <= quo_in;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alpha_wr <= 1'b0;
    end else begin
      alpha_wr <= vld_q[STAGES-1];
    end
  end

  always_ff @(posedge clk) begin
    alpha <= quo_q[STAGES-1];
  end

endmodule

// ==== softmax_ctrl.sv ====
`timescale 1ns/1ps

module softmax_ctrl import gat_softmax_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sm_valid,
  input  logic       coef_empty,
  output logic       coef_rd,
  input  node_cnt_t  num_node,
  output node_addr_t num_node_addr,
  output logic       acc_first,
  output logic       acc_last,
  output node_cnt_t  group_len,
  input  logic       dividend_full,
  input  logic       dividend_empty,
  input  logic       divisor_full,
  input  logic       divisor_empty,
  input  node_cnt_t  divisor_head_nodes,
  input  logic       alpha_full,
  output logic       div_issue,
  output logic       div_load
);
  ctrl_state_e state_q;
  ctrl_state_e state_d;
  node_cnt_t   node_cnt_q;
  node_cnt_t   group_len_q;
  node_cnt_t   len_cur;
  node_addr_t  addr_q;
  logic        rd_ok;
  logic        last_pos;
  logic        beat;
  logic        can_issue;
  logic        div_active_q;
  node_cnt_t   div_cnt_q;
  node_cnt_t   div_len_q;

  // memory data is valid from the first accumulate cycle
  assign len_cur  = (node_cnt_q == '0) ? num_node : group_len_q;
  assign last_pos = (node_cnt_q == len_cur - 1'b1);
  assign rd_ok    = sm_valid & ~coef_empty & ~dividend_full;
  // last beat also needs room for the group sum
  assign beat     = (state_q == S_ACCUM) & rd_ok & (~last_pos | ~divisor_full);

  assign coef_rd       = beat;
  assign acc_first     = (node_cnt_q == '0);
  assign acc_last      = last_pos;
  assign group_len     = len_cur;
  assign num_node_addr = addr_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_FETCH: state_d = S_ACCUM;
      S_ACCUM: begin
        if (beat && last_pos) begin
          state_d = S_FETCH;
        end else if (last_pos && divisor_full) begin
          state_d = S_WAIT;
        end
      end
      S_WAIT: begin
        if (!divisor_full) begin
          state_d = S_ACCUM;
        end
      end
      default: state_d = S_FETCH;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= S_FETCH;
      node_cnt_q <= '0;
      addr_q     <= '0;
    end else begin
      state_q <= state_d;
      if (beat) begin
        if (last_pos) begin
          node_cnt_q <= '0;
          addr_q     <= addr_q + 1'b1;
        end else begin
          node_cnt_q <= node_cnt_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_ACCUM && node_cnt_q == '0) begin
      group_len_q <= num_node;
    end
  end

  // divide side, one group behind the accumulate side
  assign can_issue = ~dividend_empty & ~alpha_full;
  assign div_load  = ~div_active_q & ~divisor_empty & can_issue;
  assign div_issue = div_active_q ? can_issue : div_load;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_active_q <= 1'b0;
      div_cnt_q    <= '0;
      div_len_q    <= '0;
    end else if (div_load) begin
      // single-node group is done with the load
      div_active_q <= (divisor_head_nodes > node_cnt_t'(1));
      div_cnt_q    <= node_cnt_t'(1);
      div_len_q    <= divisor_head_nodes;
    end else if (div_active_q && div_issue) begin
      if (div_cnt_q == div_len_q - 1'b1) begin
        div_active_q <= 1'b0;
      end
      div_cnt_q <= div_cnt_q + 1'b1;
    end
  end

endmodule

// ==== gat_softmax.sv ====
`timescale 1ns/1ps
`include "gat_softmax_consts.svh"

module gat_softmax import gat_softmax_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sm_valid,
  input  coef_t      coef,
  input  logic       coef_empty,
  output logic       coef_rd,
  input  node_cnt_t  num_node,
  output node_addr_t num_node_addr,
  input  logic       alpha_full,
  output alpha_t     alpha,
  output logic       alpha_wr
);
  logic       acc_first;
  logic       acc_last;
  node_cnt_t  group_len;
  exp_t       exp;
  logic       exp_push;
  group_sum_t group_sum;
  logic       sum_push;
  exp_t       dividend;
  logic       dividend_full;
  logic       dividend_empty;
  group_sum_t divisor_head;
  logic       divisor_full;
  logic       divisor_empty;
  logic       div_issue;
  logic       div_load;

  softmax_ctrl u_ctrl (
    .clk                (clk),
    .rst_n              (rst_n),
    .sm_valid           (sm_valid),
    .coef_empty         (coef_empty),
    .coef_rd            (coef_rd),
    .num_node           (num_node),
    .num_node_addr      (num_node_addr),
    .acc_first          (acc_first),
    .acc_last           (acc_last),
    .group_len          (group_len),
    .dividend_full      (dividend_full),
    .dividend_empty     (dividend_empty),
    .divisor_full       (divisor_full),
    .divisor_empty      (divisor_empty),
    .divisor_head_nodes (divisor_head.num_nodes),
    .alpha_full         (alpha_full),
    .div_issue          (div_issue),
    .div_load           (div_load)
  );

  exp_sum_unit u_exp_sum (
    .clk       (clk),
    .rst_n     (rst_n),
    .coef      (coef),
    .coef_rd   (coef_rd),
    .acc_first (acc_first),
    .acc_last  (acc_last),
    .group_len (group_len),
    .exp       (exp),
    .exp_push  (exp_push),
    .group_sum (group_sum),
    .sum_push  (sum_push)
  );

  sync_fifo #(
    .WIDTH ($bits(exp_t)),
    .DEPTH (`GS_DIVIDEND_DEPTH)
  ) u_dividend_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (exp),
    .wr    (exp_push),
    .rd    (div_issue),
    .dout  (dividend),
    .full  (dividend_full),
    .empty (dividend_empty)
  );

  sync_fifo #(
    .WIDTH ($bits(group_sum_t)),
    .DEPTH (`GS_DIVISOR_DEPTH)
  ) u_divisor_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (group_sum),
    .wr    (sum_push),
    .rd    (div_load),
    .dout  (divisor_head),
    .full  (divisor_full),
    .empty (divisor_empty)
  );

  fxp_div_pipe u_div (
    .clk       (clk),
    .rst_n     (rst_n),
    .div_issue (div_issue),
    .div_load  (div_load),
    .dividend  (dividend),
    .divisor   (divisor_head.sum),
    .alpha     (alpha),
    .alpha_wr  (alpha_wr)
  );

endmodule

// ==== gat_softmax_assert.sv ====
`timescale 1ns/1ps

module gat_softmax_assert (
  input logic clk,
  input logic rst_n,
  input logic coef_rd,
  input logic coef_empty,
  input logic exp_push,
  input logic dividend_full,
  input logic alpha_wr,
  input logic alpha_full,
  input logic div_issue
);

  // never read an empty coefficient source
  a_no_read_empty: assert property (
    @(posedge clk) disable iff (!rst_n) coef_rd |-> !coef_empty
  ) else $error("coef_rd high while coef_empty");

  a_no_push_full: assert property (
    @(posedge clk) disable iff (!rst_n) exp_push |-> !dividend_full
  ) else $error("dividend push while the dividend FIFO is full");

  // quiet while reset is held
  a_quiet_in_reset: assert property (
    @(posedge clk) !rst_n |-> !alpha_wr
  ) else $error("alpha_wr high during reset");

  a_issue_room: assert property (
    @(posedge clk) disable iff (!rst_n) div_issue |-> !alpha_full
  ) else $error("div_issue high while alpha_full");

endmodule

bind gat_softmax gat_softmax_assert u_assert (
  .clk           (clk),
  .rst_n         (rst_n),
  .coef_rd       (coef_rd),
  .coef_empty    (coef_empty),
  .exp_push      (exp_push),
  .dividend_full (dividend_full),
  .alpha_wr      (alpha_wr),
  .alpha_full    (alpha_full),
  .div_issue     (div_issue)
);

// ==== gat_softmax_tb.sv ====
`timescale 1ns/1ps
`include "gat_softmax_consts.svh"

module gat_softmax_tb import gat_softmax_pkg::*; ();
  localparam int NUM_GROUPS       = 40;
  localparam int RESET_CYCLES     = 5;
  localparam int CYCLES_PER_GROUP = 200;
  localparam int SINK_DEPTH       = 16;
  localparam int ALMOST_FULL      = SINK_DEPTH - `GS_DIV_LAT;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       sm_valid = 1'b0;
  coef_t      coef = '0;
  logic       coef_empty = 1'b1;
  logic       coef_rd;
  node_cnt_t  num_node = '0;
  node_addr_t num_node_addr;
  logic       alpha_full = 1'b0;
  alpha_t     alpha;
  logic       alpha_wr;

  logic [31:0] lfsr = 32'h33f6;
  node_cnt_t   grp_len [$];
  coef_t       coef_list [$];
  alpha_t      exp_alpha [$];
  int          total_coefs = 0;
  int          coef_idx = 0;
  int          grp_idx = 0;
  int          grp_pos = 0;
  node_addr_t  exp_addr = '0;
  int          sink_cnt = 0;
  int          n_alpha = 0;

  gat_softmax i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .sm_valid      (sm_valid),
    .coef          (coef),
    .coef_empty    (coef_empty),
    .coef_rd       (coef_rd),
    .num_node      (num_node),
    .num_node_addr (num_node_addr),
    .alpha_full    (alpha_full),
    .alpha         (alpha),
    .alpha_wr      (alpha_wr)
  );

  always #4 clk = ~clk;

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "run stopped");
  endtask

  task automatic check_alpha(input alpha_t got, input alpha_t expv);
    if (got !== expv) begin
      abort_run($sformatf("mismatch alpha: got %h expected %h", got, expv));
    end
  endtask

  task automatic check_addr(input node_addr_t got, input node_addr_t expv);
    if (got !== expv) begin
      abort_run($sformatf("mismatch num_node_addr: got %h expected %h", got, expv));
    end
  endtask

  // groups 0 and 1 hold the edge cases
  task automatic build_stimulus();
    node_cnt_t len;
    coef_t     c;
    coef_t     grp [$];
    longint    sum;
    for (int g = 0; g < NUM_GROUPS; g++) begin
      if (g == 0) begin
        len = node_cnt_t'(1);
      end else if (g == 1) begin
        len = node_cnt_t'(16);
      end else begin
        len = node_cnt_t'(rand_bits(4) + 1);
      end
      grp_len.push_back(len);
      grp.delete();
      sum = 0;
      for (int i = 0; i < int'(len); i++) begin
        c = (g == 1) ? coef_t'(15) : coef_t'(rand_bits(4));
        grp.push_back(c);
        coef_list.push_back(c);
        sum = sum + (longint'(1) << c);
      end
      // alpha = floor(2^c * 2^frac / sum)
      foreach (grp[i]) begin
        exp_alpha.push_back(alpha_t'((longint'(1) << (grp[i] + `GS_ALPHA_FRAC)) / sum));
      end
    end
    total_coefs = coef_list.size();
  endtask

  function automatic node_cnt_t mem_read(input node_addr_t a);
    if (int'(a) < NUM_GROUPS) begin
      return grp_len[a];
    end
    return node_cnt_t'(1);
  endfunction

  // sample at the edge and drive the next cycle's inputs
  always @(posedge clk) begin
    if (!rst_n) begin
      check_addr(num_node_addr, '0);
      if (coef_rd || alpha_wr) begin
        abort_run("DUT outputs were active during reset");
      end
    end else begin
      check_addr(num_node_addr, exp_addr);
      if (coef_rd) begin
        if (coef_empty) begin
          abort_run("coefficient read while the source was empty");
        end
        if (!sm_valid) begin
          abort_run("coefficient read while sm_valid was low");
        end
        coef_idx = coef_idx + 1;
        grp_pos = grp_pos + 1;
        if (grp_pos == int'(grp_len[grp_idx])) begin
          grp_idx = grp_idx + 1;
          grp_pos = 0;
          exp_addr = node_addr_t'(grp_idx);
        end
      end
      if (alpha_wr) begin
        if (exp_alpha.size() == 0) begin
          abort_run("alpha written with no result outstanding");
        end
        if (sink_cnt == SINK_DEPTH) begin
          abort_run("alpha sink overflowed");
        end
        check_alpha(alpha, exp_alpha.pop_front());
        n_alpha = n_alpha + 1;
        sink_cnt = sink_cnt + 1;
      end
      if (sink_cnt > 0 && rand_bits(1) != 0) begin
        sink_cnt = sink_cnt - 1;
      end
    end
    sm_valid   <= (rand_bits(3) != 0);
    coef       <= (coef_idx < total_coefs) ? coef_list[coef_idx] : '0;
    coef_empty <= (coef_idx >= total_coefs) || (rand_bits(2) == 0);
    num_node   <= mem_read(num_node_addr);
    alpha_full <= (sink_cnt >= ALMOST_FULL);
  end

  initial begin
    repeat (NUM_GROUPS * CYCLES_PER_GROUP + RESET_CYCLES) @(posedge clk);
    abort_run("timeout: not all alpha results arrived in time");
  end

  initial begin
    rst_n = 1'b0;
    build_stimulus();
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    while (n_alpha < total_coefs) begin
      @(negedge clk);
    end
    // drain window for a stray alpha_wr
    repeat (2 * `GS_DIV_LAT) @(negedge clk);
    check_addr(num_node_addr, node_addr_t'(NUM_GROUPS));
    if (coef_idx == total_coefs) begin
      $display("Done: no errors");
      $finish;
    end else begin
      abort_run("not every coefficient was read");
    end
  end

endmodule

// ==== gat_softmax.f ====
+incdir+.
gat_softmax_pkg.sv
sync_fifo.sv
exp_sum_unit.sv
fxp_div_pipe.sv
softmax_ctrl.sv
gat_softmax.sv
gat_softmax_assert.sv
gat_softmax_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= gat_softmax_tb
FLIST     ?= gat_softmax.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

FAIL_MSG = Done: errors found
PASS_MSG = Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "test FAILED"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "test PASSED"; \
	else \
	  echo "test FAILED, no result in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
